/* source/icache_params.svh */
// icache geometry macros

`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// ==================================================
// address split
// ==================================================
`define ICACHE_ADDR_W      32
`define ICACHE_OFFSET_W    3
`define ICACHE_INDEX_W     8
`define ICACHE_TAG_W       21

// ==================================================
// geometry and payload widths
// ==================================================
`define ICACHE_SETS        256
`define ICACHE_BLOCK_W     64
`define ICACHE_INST_W      32

// AXI read response code for a good beat
`define ICACHE_RESP_OKAY   2'b00

`endif

/* source/icache_pkg.sv */
// icache shared types

`include "icache_params.svh"

package icache_pkg;

    // ==================================================
    // address fields
    // ==================================================
    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;

    // ==================================================
    // payloads
    // ==================================================
    // one cached block, two instructions
    typedef logic [`ICACHE_BLOCK_W-1:0] block_t;
    typedef logic [`ICACHE_INST_W-1:0]  inst_t;

    // tag store entry
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // AXI read response
    typedef logic [1:0] resp_t;

endpackage

/* source/refill_if.sv */
// block refill link

`timescale 1ns/1ps

`include "icache_params.svh"

interface refill_if;

    // request side, one-cycle start with aligned block address
    logic                      start;
    logic [`ICACHE_ADDR_W-1:0] addr;

    // answer side, exactly one done per start
    logic                      done;
    icache_pkg::block_t        data;
    logic                      error;

    modport ctrl (
        output start,
        output addr,
        input  done,
        input  data,
        input  error
    );

    modport master (
        input  start,
        input  addr,
        output done,
        output data,
        output error
    );

endinterface

/* source/way_store.sv */
// per-way set storage

`timescale 1ns/1ps

`include "icache_params.svh"

module way_store #(
    parameter type entry_t = icache_pkg::block_t,
    parameter int  DEPTH   = `ICACHE_SETS
) (
    input  logic               clk,
    input  logic               rd_en,
    input  icache_pkg::index_t rd_index,
    output entry_t             rd_entry,
    input  logic               wr_en,
    input  icache_pkg::index_t wr_index,
    input  entry_t             wr_entry,
    input  logic               rst
);

    entry_t mem [DEPTH];

    // write port, cleared on reset so no stale valid bits survive
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_index] <= wr_entry;
        end
    end

    // synchronous read
    // same-edge write to the same set is forwarded
    always_ff @(posedge clk) begin
        if (rd_en) begin
            if (wr_en && (wr_index == rd_index)) begin
                rd_entry <= wr_entry;
            end else begin
                rd_entry <= mem[rd_index];
            end
        end
    end

endmodule

/* source/axi_read_master.sv */
// AXI single-beat read master

`timescale 1ns/1ps

`include "icache_params.svh"

module axi_read_master (
    input  logic                      clk,
    input  logic                      rst,

    refill_if.master                  bus,

    // AR channel
    output logic                      ar_valid,
    output logic [`ICACHE_ADDR_W-1:0] ar_addr,
    input  logic                      ar_ready,

    // R channel
    input  logic                      r_valid,
    output logic                      r_ready,
    input  icache_pkg::block_t        r_data,
    input  icache_pkg::resp_t         r_resp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_WAIT
    } state_t;

    state_t state;
    state_t state_next;

    logic   beat_taken;
    logic   done_q;
    logic   error_q;

    icache_pkg::block_t data_q;

    // ==================================================
    // bus FSM
    // ==================================================
    assign beat_taken = r_valid & r_ready;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (bus.start) begin
                    state_next = ST_ADDR;
                end
            end
            ST_ADDR: begin
                // address stays up until the slave takes it
                if (ar_ready) begin
                    state_next = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (r_valid) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // block address latched at start
    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && bus.start) begin
            ar_addr <= bus.addr;
        end
    end

    assign ar_valid = (state == ST_ADDR);
    assign r_ready  = (state == ST_WAIT);

    // ==================================================
    // beat capture and done strobe
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            done_q <= 1'b0;
        end else begin
            done_q <= beat_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_taken) begin
            data_q  <= r_data;
            error_q <= (r_resp != `ICACHE_RESP_OKAY);
        end
    end

    assign bus.done  = done_q;
    assign bus.data  = data_q;
    assign bus.error = error_q;

endmodule

/* source/icache_ctrl.sv */
// icache lookup and refill control

`timescale 1ns/1ps

`include "icache_params.svh"

module icache_ctrl (
    input  logic                      clk,
    input  logic                      rst,

    // fetch side
    input  logic                      fetch_req,
    input  logic [`ICACHE_ADDR_W-1:0] fetch_pc,
    input  logic                      flush,
    output logic                      inst_valid,
    output icache_pkg::inst_t         inst,
    output logic                      inst_error,
    output logic                      busy,

    refill_if.ctrl                    refill,

    // lookup, shared by all four stores
    output logic                      rd_en,
    output icache_pkg::index_t        rd_index,
    input  icache_pkg::tag_entry_t    tag0_rd_entry,
    input  icache_pkg::tag_entry_t    tag1_rd_entry,
    input  icache_pkg::block_t        data0_rd_entry,
    input  icache_pkg::block_t        data1_rd_entry,

    // fill, tag and data of one way written together
    output logic                      way0_wr_en,
    output logic                      way1_wr_en,
    output icache_pkg::index_t        wr_index,
    output icache_pkg::tag_entry_t    tag_wr_entry,
    output icache_pkg::block_t        data_wr_entry
);

    logic [`ICACHE_ADDR_W-1:0] pc_q;
    logic                      req_q;
    logic                      hit_q;
    logic                      start_q;
    logic                      pending;
    logic                      discard;
    logic [`ICACHE_SETS-1:0]   repl;

    icache_pkg::tag_t   pc_tag;
    icache_pkg::index_t pc_index;
    logic               pc_hi;
    logic               hit0;
    logic               hit1;
    logic               lookup_hit;
    logic               victim;
    logic               fill;
    logic               refill_resp;
    icache_pkg::block_t hit_block;
    icache_pkg::inst_t  hit_inst_q;

    // picks the word of a block named by pc bit 2
    function automatic icache_pkg::inst_t pick_half(input icache_pkg::block_t blk,
                                                    input logic hi);
        if (hi) begin
            return blk[`ICACHE_BLOCK_W-1:`ICACHE_INST_W];
        end
        return blk[`ICACHE_INST_W-1:0];
    endfunction

    // ==================================================
    // stage 1: request register and store read
    // ==================================================
    assign rd_en    = fetch_req;
    assign rd_index = fetch_pc[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];

    always_ff @(posedge clk) begin
        if (fetch_req) begin
            pc_q <= fetch_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= 1'b0;
        end else begin
            req_q <= fetch_req;
        end
    end

    assign pc_tag   = pc_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign pc_index = pc_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign pc_hi    = pc_q[`ICACHE_OFFSET_W-1];

    // ==================================================
    // stage 2: compare and hit response
    // ==================================================
    assign hit0       = tag0_rd_entry.valid && (tag0_rd_entry.tag == pc_tag);
    assign hit1       = tag1_rd_entry.valid && (tag1_rd_entry.tag == pc_tag);
    assign lookup_hit = hit0 | hit1;
    assign hit_block  = hit0 ? data0_rd_entry : data1_rd_entry;

    always_ff @(posedge clk) begin
        if (rst) begin
            hit_q   <= 1'b0;
            start_q <= 1'b0;
        end else begin
            // a flush drops the request still in lookup
            hit_q   <= req_q & lookup_hit & ~flush;
            start_q <= req_q & ~lookup_hit & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        if (req_q) begin
            hit_inst_q <= pick_half(hit_block, pc_hi);
        end
    end

    // ==================================================
    // refill tracking
    // ==================================================
    assign refill.start = start_q;
    assign refill.addr  = {pc_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            discard <= 1'b0;
        end else if (refill.done) begin
            pending <= 1'b0;
            discard <= 1'b0;
        end else begin
            if (req_q && !lookup_hit && !flush) begin
                pending <= 1'b1;
            end
            // answer is thrown away but the line still fills
            if (pending && flush) begin
                discard <= 1'b1;
            end
        end
    end

    // one replacement bit per set, flips on each good fill
    assign victim = repl[pc_index];
    assign fill   = refill.done & ~refill.error;

    always_ff @(posedge clk) begin
        if (rst) begin
            repl <= '0;
        end else if (fill) begin
            repl[pc_index] <= ~repl[pc_index];
        end
    end

    assign way0_wr_en    = fill & ~victim;
    assign way1_wr_en    = fill & victim;
    assign wr_index      = pc_index;
    assign tag_wr_entry  = '{valid: 1'b1, tag: pc_tag};
    assign data_wr_entry = refill.data;

    // ==================================================
    // response merge
    // ==================================================
    assign refill_resp = refill.done & pending & ~discard;

    assign inst_valid = hit_q | refill_resp;
    assign inst       = refill_resp ? pick_half(refill.data, pc_hi) : hit_inst_q;
    assign inst_error = refill_resp & refill.error;

    // low again in the cycle of the response
    assign busy = req_q | (pending & ~refill.done);

endmodule

/* source/icache_top.sv */
// two-way instruction cache

`timescale 1ns/1ps

`include "icache_params.svh"

module icache_top (
    input  logic                      clk,
    input  logic                      rst,

    // fetch requester
    input  logic                      fetch_req,
    input  logic [`ICACHE_ADDR_W-1:0] fetch_pc,
    input  logic                      flush,
    output logic                      inst_valid,
    output icache_pkg::inst_t         inst,
    output logic                      inst_error,
    output logic                      busy,

    // AXI read master
    output logic                      ar_valid,
    output logic [`ICACHE_ADDR_W-1:0] ar_addr,
    input  logic                      ar_ready,
    input  logic                      r_valid,
    output logic                      r_ready,
    input  icache_pkg::block_t        r_data,
    input  icache_pkg::resp_t         r_resp
);

    refill_if refill_bus ();

    logic                   rd_en;
    icache_pkg::index_t     rd_index;
    icache_pkg::tag_entry_t tag0_rd_entry;
    icache_pkg::tag_entry_t tag1_rd_entry;
    icache_pkg::block_t     data0_rd_entry;
    icache_pkg::block_t     data1_rd_entry;
    logic                   way0_wr_en;
    logic                   way1_wr_en;
    icache_pkg::index_t     wr_index;
    icache_pkg::tag_entry_t tag_wr_entry;
    icache_pkg::block_t     data_wr_entry;

    // ==================================================
    // control and bus
    // ==================================================
    icache_ctrl icache_ctrl_inst (
        .clk            (clk),
        .rst            (rst),
        .fetch_req      (fetch_req),
        .fetch_pc       (fetch_pc),
        .flush          (flush),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .inst_error     (inst_error),
        .busy           (busy),
        .refill         (refill_bus.ctrl),
        .rd_en          (rd_en),
        .rd_index       (rd_index),
        .tag0_rd_entry  (tag0_rd_entry),
        .tag1_rd_entry  (tag1_rd_entry),
        .data0_rd_entry (data0_rd_entry),
        .data1_rd_entry (data1_rd_entry),
        .way0_wr_en     (way0_wr_en),
        .way1_wr_en     (way1_wr_en),
        .wr_index       (wr_index),
        .tag_wr_entry   (tag_wr_entry),
        .data_wr_entry  (data_wr_entry)
    );

    axi_read_master axi_read_master_inst (
        .clk      (clk),
        .rst      (rst),
        .bus      (refill_bus.master),
        .ar_valid (ar_valid),
        .ar_addr  (ar_addr),
        .ar_ready (ar_ready),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_data   (r_data),
        .r_resp   (r_resp)
    );

    // ==================================================
    // tag and data stores, one pair per way
    // ==================================================
    way_store #(.entry_t(icache_pkg::tag_entry_t), .DEPTH(`ICACHE_SETS)) tag0_store_inst (
        .clk(clk), .rd_en(rd_en), .rd_index(rd_index), .rd_entry(tag0_rd_entry),
        .wr_en(way0_wr_en), .wr_index(wr_index), .wr_entry(tag_wr_entry), .rst(rst)
    );

    way_store #(.entry_t(icache_pkg::tag_entry_t), .DEPTH(`ICACHE_SETS)) tag1_store_inst (
        .clk(clk), .rd_en(rd_en), .rd_index(rd_index), .rd_entry(tag1_rd_entry),
        .wr_en(way1_wr_en), .wr_index(wr_index), .wr_entry(tag_wr_entry), .rst(rst)
    );

    way_store #(.entry_t(icache_pkg::block_t), .DEPTH(`ICACHE_SETS)) data0_store_inst (
        .clk(clk), .rd_en(rd_en), .rd_index(rd_index), .rd_entry(data0_rd_entry),
        .wr_en(way0_wr_en), .wr_index(wr_index), .wr_entry(data_wr_entry), .rst(rst)
    );

    way_store #(.entry_t(icache_pkg::block_t), .DEPTH(`ICACHE_SETS)) data1_store_inst (
        .clk(clk), .rd_en(rd_en), .rd_index(rd_index), .rd_entry(data1_rd_entry),
        .wr_en(way1_wr_en), .wr_index(wr_index), .wr_entry(data_wr_entry), .rst(rst)
    );

endmodule

/* test/icache_properties.sv */
// icache bound assertions

`timescale 1ns/1ps

`include "icache_params.svh"

module icache_properties (
    input logic                      clk,
    input logic                      rst,
    input logic                      ar_valid,
    input logic [`ICACHE_ADDR_W-1:0] ar_addr,
    input logic                      ar_ready,
    input logic                      inst_valid,
    input logic                      start,
    input logic                      pending
);

    // AR request holds with a stable address until accepted
    property ar_hold_p;
        @(posedge clk) disable iff (rst)
        (ar_valid && !ar_ready) |=> (ar_valid && $stable(ar_addr));
    endproperty

    property inst_single_p;
        @(posedge clk) disable iff (rst)
        inst_valid |=> !inst_valid;
    endproperty

    // new refill only once the previous one has finished
    property start_idle_p;
        @(posedge clk) disable iff (rst)
        start |-> !$past(pending);
    endproperty

    ar_hold_a: assert property (ar_hold_p)
        else $error("ar_valid dropped or ar_addr moved before ar_ready");

    inst_single_a: assert property (inst_single_p)
        else $error("inst_valid high in two cycles running");

    start_idle_a: assert property (start_idle_p)
        else $error("refill start while a refill was outstanding");

endmodule

bind axi_read_master icache_properties bus_props (
    .clk        (clk),
    .rst        (rst),
    .ar_valid   (ar_valid),
    .ar_addr    (ar_addr),
    .ar_ready   (ar_ready),
    .inst_valid (1'b0),
    .start      (1'b0),
    .pending    (1'b0)
);

bind icache_ctrl icache_properties ctrl_props (
    .clk        (clk),
    .rst        (rst),
    .ar_valid   (1'b0),
    .ar_addr    ('0),
    .ar_ready   (1'b0),
    .inst_valid (inst_valid),
    .start      (start_q),
    .pending    (pending)
);

/* test/icache_tb.sv */
// icache directed testbench

`timescale 1ns/1ps

`include "icache_params.svh"

module icache_tb;

    localparam int          RESP_TIMEOUT = 60;
    localparam logic [31:0] ERR_BASE     = 32'hF000_0000;
    localparam logic [31:0] DATA_KEY     = 32'hA5A5_0000;

    logic                      clk;
    logic                      rst;
    logic                      fetch_req;
    logic [`ICACHE_ADDR_W-1:0] fetch_pc;
    logic                      flush;
    logic                      inst_valid;
    icache_pkg::inst_t         inst;
    logic                      inst_error;
    logic                      busy;
    logic                      ar_valid;
    logic [`ICACHE_ADDR_W-1:0] ar_addr;
    logic                      ar_ready;
    logic                      r_valid;
    logic                      r_ready;
    icache_pkg::block_t        r_data;
    icache_pkg::resp_t         r_resp;

    int          ar_count;
    logic [31:0] last_ar_addr;
    int          error_count;
    int          check_count;
    int          tests_run;
    int          tests_failed;
    int          test_err_base;
    string       test_name;

    // reference model, all clear like the DUT after reset
    bit               model_valid [2][`ICACHE_SETS];
    icache_pkg::tag_t model_tag   [2][`ICACHE_SETS];
    bit               model_repl  [`ICACHE_SETS];

    icache_top icache_top_inst (
        .clk        (clk),
        .rst        (rst),
        .fetch_req  (fetch_req),
        .fetch_pc   (fetch_pc),
        .flush      (flush),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_error (inst_error),
        .busy       (busy),
        .ar_valid   (ar_valid),
        .ar_addr    (ar_addr),
        .ar_ready   (ar_ready),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .r_data     (r_data),
        .r_resp     (r_resp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #200000;
        $display("run time limit reached, simulation stopped");
        $display("=== FAIL ===");
        $finish;
    end

    // ==================================================
    // reference rules
    // ==================================================
    // slave data: low word is aligned address ^ key, high word that plus 4
    function automatic logic [63:0] block_for(input logic [31:0] addr);
        logic [31:0] lo;
        lo = {addr[31:3], 3'b000} ^ DATA_KEY;
        return {lo + 32'd4, lo};
    endfunction

    function automatic logic [31:0] expected_inst(input logic [31:0] pc);
        logic [31:0] lo;
        lo = {pc[31:3], 3'b000} ^ DATA_KEY;
        return pc[2] ? lo + 32'd4 : lo;
    endfunction

    function automatic bit model_hit(input logic [31:0] pc);
        icache_pkg::index_t idx;
        idx = pc[10:3];
        return (model_valid[0][idx] && (model_tag[0][idx] == pc[31:11])) ||
               (model_valid[1][idx] && (model_tag[1][idx] == pc[31:11]));
    endfunction

    // good refill goes to the way named by the set's bit, which then flips
    function automatic void model_fill(input logic [31:0] pc);
        icache_pkg::index_t idx;
        bit                 way;
        idx = pc[10:3];
        way = model_repl[idx];
        if (pc < ERR_BASE) begin
            model_valid[way][idx] = 1'b1;
            model_tag[way][idx]   = pc[31:11];
            model_repl[idx]       = !way;
        end
    endfunction

    // ==================================================
    // AXI slave model
    // ==================================================
    initial begin : slave_model
        int unsigned wait_cycles;
        logic [31:0] addr;
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_data   = '0;
        r_resp   = `ICACHE_RESP_OKAY;
        ar_count = 0;
        forever begin
            @(posedge clk);
            #1;
            if (ar_valid === 1'b1) begin
                wait_cycles = $urandom % 4;
                repeat (wait_cycles) begin
                    @(posedge clk);
                    #1;
                end
                ar_ready = 1'b1;
                addr     = ar_addr;
                @(posedge clk);
                #1;
                ar_ready     = 1'b0;
                ar_count     = ar_count + 1;
                last_ar_addr = addr;
                wait_cycles  = $urandom % 4;
                repeat (wait_cycles) begin
                    @(posedge clk);
                    #1;
                end
                r_valid = 1'b1;
                r_data  = block_for(addr);
                // SLVERR for the error region
                r_resp  = (addr >= ERR_BASE) ? 2'b10 : `ICACHE_RESP_OKAY;
                @(posedge clk);
                #1;
                r_valid = 1'b0;
            end
        end
    end

    // ==================================================
    // check and bookkeeping helpers
    // ==================================================
    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("%s: %s", test_name, msg);
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        test_err_base = error_count;
        tests_run++;
    endtask

    task automatic finish_test();
        if (error_count == test_err_base) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, error_count - test_err_base);
        end
    endtask

    // one fetch, response and AR traffic checked, model updated
    task automatic fetch_check(input logic [31:0] pc, input int exp_ars);
        int          cycles;
        int          ar_before;
        bit          was_hit;
        bit          got;
        int          got_lat;
        logic [31:0] got_inst;
        logic        got_err;
        was_hit   = model_hit(pc);
        ar_before = ar_count;
        got       = 1'b0;
        got_lat   = 0;
        got_inst  = '0;
        got_err   = 1'b0;
        cycles    = 0;
        fetch_req = 1'b1;
        fetch_pc  = pc;
        @(posedge clk);
        #1;
        fetch_req = 1'b0;
        // busy drops in the response cycle
        do begin
            @(posedge clk);
            #1;
            cycles++;
            if (inst_valid && !got) begin
                got      = 1'b1;
                got_lat  = cycles;
                got_inst = inst;
                got_err  = inst_error;
            end
        end while (busy && cycles < RESP_TIMEOUT);
        if (busy) begin
            report_failure($sformatf("no response to the fetch at pc %h", pc));
        end
        check_value("response", 1, got);
        if (pc >= ERR_BASE) begin
            check_value("inst_error", 1, got_err);
        end else begin
            check_value("inst_error", 0, got_err);
            check_value("inst", expected_inst(pc), got_inst);
        end
        check_value("AR count", exp_ars, ar_count - ar_before);
        if (exp_ars == 0) begin
            // response sampled at edge n+2
            check_value("hit latency", 1, got_lat);
        end else begin
            check_value("AR address", {pc[31:3], 3'b000}, last_ar_addr);
        end
        if (!was_hit) begin
            model_fill(pc);
        end
    endtask

    // ==================================================
    // directed tests
    // ==================================================
    task automatic test_reset();
        start_test("reset");
        check_value("ar_valid", 0, ar_valid);
        check_value("r_ready", 0, r_ready);
        check_value("inst_valid", 0, inst_valid);
        check_value("inst_error", 0, inst_error);
        check_value("busy", 0, busy);
        finish_test();
    endtask

    task automatic test_miss_then_hit();
        start_test("miss_then_hit");
        fetch_check(32'h0000_1004, 1);
        fetch_check(32'h0000_1004, 0);
        // other word of the same block
        fetch_check(32'h0000_1000, 0);
        finish_test();
    endtask

    task automatic test_two_ways();
        logic [31:0] pc_a;
        logic [31:0] pc_b;
        logic [31:0] pc_c;
        pc_a = {21'h00011, 8'h40, 3'b000};
        pc_b = {21'h00022, 8'h40, 3'b100};
        pc_c = {21'h00033, 8'h40, 3'b000};
        start_test("two_ways");
        fetch_check(pc_a, 1);
        fetch_check(pc_b, 1);
        fetch_check(pc_a, 0);
        fetch_check(pc_b, 0);
        // bit is back on way 0, so C replaces A
        fetch_check(pc_c, 1);
        fetch_check(pc_b, 0);
        fetch_check(pc_a, 1);
        finish_test();
    endtask

    task automatic test_error_resp();
        start_test("error_resp");
        fetch_check(32'hF000_0104, 1);
        // line stays invalid so the retry goes to the bus again
        fetch_check(32'hF000_0104, 1);
        finish_test();
    endtask

    task automatic test_flush_miss();
        logic [31:0] pc;
        int          cycles;
        int          ar_before;
        bit          seen;
        pc        = 32'h0000_2208;
        seen      = 1'b0;
        cycles    = 0;
        start_test("flush_miss");
        ar_before = ar_count;
        fetch_req = 1'b1;
        fetch_pc  = pc;
        @(posedge clk);
        #1;
        fetch_req = 1'b0;
        while (!ar_valid && cycles < RESP_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            seen = seen | inst_valid;
        end
        if (!ar_valid) begin
            report_failure("the miss never raised ar_valid");
        end
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush  = 1'b0;
        seen   = seen | inst_valid;
        cycles = 0;
        while (busy && cycles < RESP_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
            seen = seen | inst_valid;
        end
        if (busy) begin
            report_failure("busy stayed high after the flushed refill");
        end
        check_value("response after flush", 0, seen);
        check_value("AR count", 1, ar_count - ar_before);
        // the flushed refill still fills its line
        model_fill(pc);
        fetch_check(pc, 0);
        finish_test();
    endtask

    task automatic test_random_traffic();
        icache_pkg::index_t idx_pool [3];
        icache_pkg::tag_t   tag_pool [5];
        logic [31:0]        pc;
        idx_pool = '{8'h10, 8'h11, 8'h12};
        tag_pool = '{21'h00100, 21'h00200, 21'h00300, 21'h00400, 21'h1E0000};
        start_test("random_traffic");
        for (int i = 0; i < 40; i++) begin
            pc    = {tag_pool[$urandom % 5], idx_pool[$urandom % 3], 3'b000};
            pc[2] = ($urandom % 2) == 1;
            fetch_check(pc, model_hit(pc) ? 0 : 1);
        end
        finish_test();
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        void'($urandom(32'h6d44a195));
        error_count  = 0;
        check_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst          = 1'b1;
        fetch_req    = 1'b0;
        fetch_pc     = '0;
        flush        = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset();
        test_miss_then_hit();
        test_two_ways();
        test_error_resp();
        test_flush_miss();
        test_random_traffic();
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+source
source/icache_pkg.sv
source/refill_if.sv
source/way_store.sv
source/axi_read_master.sv
source/icache_ctrl.sv
source/icache_top.sv
test/icache_properties.sv
test/icache_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module icache_tb -f compile.f

./obj_dir/Vicache_tb | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
